//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= irq_stim_gen_tb
FILELIST  ?= all.f
PASS_MSG  := Result: PASSED
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- all.f
verilog/irq_gen_pkg.sv
verilog/irq_rand_source.sv
verilog/irq_pc_trigger.sv
verilog/irq_sw_sampler.sv
verilog/irq_mode_select.sv
verilog/irq_stim_gen.sv
test/irq_stim_gen_sva.sv
test/irq_stim_gen_tb.sv

//--- test/irq_stim_gen_sva.sv
`timescale 1ns/1ps
`default_nettype none

module irq_stim_gen_sva import irq_gen_pkg::*; (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire logic [31:0]              irq_mode_i,
  input wire logic [31:0]              irq_min_id_i,
  input wire logic [31:0]              irq_max_id_i,
  input wire logic [IRQ_LINES_NUM-1:0] irq_rnd_lines_o,
  input wire logic [31:0]              irq_act_id_o,
  input wire logic                     irq_id_we_o
);

  // STANDARD on the mode input passes the mode register, then the output register
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_mode_i == STANDARD) |-> ##2 (irq_rnd_lines_o == '0))
    else $error("Lines still raised two cycles into STANDARD");

  // Write enable is a single cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_id_we_o |=> !irq_id_we_o)
    else $error("ID write enable held for two cycles");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_act_id_o != '0) |-> (irq_act_id_o >= irq_min_id_i && irq_act_id_o <= irq_max_id_i))
    else $error("Active ID outside the ID bounds");

endmodule

bind irq_stim_gen irq_stim_gen_sva irq_stim_gen_sva_inst (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .irq_mode_i      (irq_mode_i),
  .irq_min_id_i    (irq_min_id_i),
  .irq_max_id_i    (irq_max_id_i),
  .irq_rnd_lines_o (irq_rnd_lines_o),
  .irq_act_id_o    (irq_act_id_o),
  .irq_id_we_o     (irq_id_we_o)
);

`default_nettype wire

//--- test/irq_stim_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irq_stim_gen_tb import irq_gen_pkg::*; ();

  // Tests take about 130 cycles in all, the limit leaves margin
  localparam int TIMEOUT_CYCLES = 300;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     irq_i;
  logic                     irq_ack_i;
  logic [31:0]              irq_mode_i;
  logic [31:0]              irq_min_cycles_i;
  logic [31:0]              irq_max_cycles_i;
  logic [31:0]              irq_min_id_i;
  logic [31:0]              irq_max_id_i;
  logic [31:0]              irq_pc_id_i;
  logic [31:0]              irq_pc_trig_i;
  logic [IRQ_WORD_W-1:0]    irq_lines_i;
  logic [IRQ_LINES_NUM-1:0] irq_rnd_lines_o;
  logic                     irq_ack_o;
  logic [31:0]              irq_act_id_o;
  logic                     irq_id_we_o;

  logic [15:0] lfsr_q;
  int          errors;
  int          checks;
  int          cycle_cnt = 0;

  irq_stim_gen irq_stim_gen_inst (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit of the word
  task automatic draw_word(output logic [63:0] w);
    w = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[62:0], lfsr_q[0]};
    end
  endtask

  // Software bit 3, timer bit 7, external bit 11, fast bits 63..16
  function automatic logic [IRQ_LINES_NUM-1:0] expected_lines(input logic [63:0] w);
    logic [IRQ_LINES_NUM-1:0] l;
    l[50]   = w[3];
    l[49]   = w[7];
    l[48]   = w[11];
    l[47:0] = w[63:16];
    return l;
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // n rising edges, then sample at the falling edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_and_standard();
    logic [63:0] w;
    compare_value("reset_lines", '0, 64'(irq_rnd_lines_o));
    compare_value("reset_id_we", '0, 64'(irq_id_we_o));
    compare_value("reset_act_id", '0, 64'(irq_act_id_o));
    draw_word(w);
    // Line word and a PC match, both ignored in STANDARD
    @(posedge clk_i);
    irq_lines_i <= w;
    irq_pc_id_i <= irq_pc_trig_i;
    wait_cycles(4);
    compare_value("standard_lines", '0, 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_lines_i <= '0;
    irq_pc_id_i <= 32'h200;
  endtask

  task automatic software_defined_lines();
    logic [63:0]              w;
    logic [IRQ_LINES_NUM-1:0] last;
    @(posedge clk_i);
    irq_mode_i <= SOFTWARE_DEFINED;
    wait_cycles(2);
    for (int n = 0; n < 6; n++) begin
      draw_word(w);
      @(posedge clk_i);
      irq_lines_i <= w;
      wait_cycles(2);
      compare_value("sw_word", 64'(expected_lines(w)), 64'(irq_rnd_lines_o));
    end
    // Only reserved bits set, nothing reaches the lines
    @(posedge clk_i);
    irq_lines_i <= 64'hF777;
    wait_cycles(2);
    compare_value("sw_reserved", 64'(expected_lines(64'hF777)), 64'(irq_rnd_lines_o));
    draw_word(w);
    @(posedge clk_i);
    irq_lines_i <= w;
    wait_cycles(2);
    compare_value("sw_word", 64'(expected_lines(w)), 64'(irq_rnd_lines_o));
    last = expected_lines(w);
    // Zero word keeps the last lines
    @(posedge clk_i);
    irq_lines_i <= '0;
    wait_cycles(3);
    compare_value("sw_zero_hold", 64'(last), 64'(irq_rnd_lines_o));
    // Raised lines drop when the mode returns to STANDARD
    @(posedge clk_i);
    irq_lines_i <= '0;
    irq_mode_i  <= STANDARD;
    wait_cycles(2);
    compare_value("sw_leave", '0, 64'(irq_rnd_lines_o));
  endtask

  task automatic random_lines_window();
    logic [63:0]              mask;
    logic [IRQ_LINES_NUM-1:0] held;
    int                       waited;
    for (int i = 0; i < 64; i++) begin
      mask[i] = (32'(i) >= irq_min_id_i) && (32'(i) <= irq_max_id_i);
    end
    @(posedge clk_i);
    irq_mode_i <= RANDOM;
    waited = 0;
    while (irq_rnd_lines_o == '0 && waited < 32) begin
      wait_cycles(1);
      waited++;
    end
    // Mode register edge, W wait cycles, up to three more for the pipeline
    checks++;
    assert (waited >= irq_min_cycles_i + 1 && waited <= irq_max_cycles_i + 4) else begin
      errors++;
      $display("ERROR random_window: expected %0d..%0d cycles, actual %0d",
               irq_min_cycles_i + 1, irq_max_cycles_i + 4, waited);
    end
    compare_value("random_subset", '0, 64'(irq_rnd_lines_o & ~expected_lines(mask)));
    held = irq_rnd_lines_o;
    wait_cycles(6);
    compare_value("random_hold", 64'(held), 64'(irq_rnd_lines_o));
    checks++;
    assert (irq_act_id_o == '0 ||
            (irq_act_id_o >= irq_min_id_i && irq_act_id_o <= irq_max_id_i)) else begin
      errors++;
      $display("ERROR random_act_id: expected 0 or %0d..%0d, actual %0d",
               irq_min_id_i, irq_max_id_i, irq_act_id_o);
    end
    @(posedge clk_i);
    irq_mode_i <= STANDARD;
    wait_cycles(2);
    compare_value("random_clear", '0, 64'(irq_rnd_lines_o));
    compare_value("random_id_clear", '0, 64'(irq_act_id_o));
  endtask

  task automatic pc_trigger_sequence();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    draw_word(a);
    draw_word(b);
    draw_word(c);
    @(posedge clk_i);
    irq_lines_i <= a;
    irq_mode_i  <= PC_TRIG;
    wait_cycles(5);
    compare_value("pc_mismatch", '0, 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_pc_id_i <= irq_pc_trig_i;
    wait_cycles(2);
    compare_value("pc_match", 64'(expected_lines(64'h8)), 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_pc_id_i <= 32'h204;
    wait_cycles(3);
    compare_value("pc_hold", 64'(expected_lines(64'h8)), 64'(irq_rnd_lines_o));
    // First change after the match replaces the lines
    @(posedge clk_i);
    irq_lines_i <= b;
    wait_cycles(2);
    compare_value("pc_change", 64'(expected_lines(b)), 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_lines_i <= c;
    wait_cycles(3);
    compare_value("pc_done", 64'(expected_lines(b)), 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_lines_i <= '0;
    irq_mode_i  <= STANDARD;
    wait_cycles(2);
    compare_value("pc_leave", '0, 64'(irq_rnd_lines_o));
  endtask

  // Ack high for len cycles, one write enable pulse in the second cycle
  task automatic acknowledge_pulse(input int len);
    @(posedge clk_i);
    irq_ack_i <= 1'b1;
    for (int k = 0; k < len + 3; k++) begin
      @(negedge clk_i);
      compare_value("ack_through", 64'(k < len), 64'(irq_ack_o));
      compare_value("ack_id_we", 64'(k == 1), 64'(irq_id_we_o));
      @(posedge clk_i);
      if (k + 1 == len) begin
        irq_ack_i <= 1'b0;
      end
    end
  endtask

  task automatic unknown_mode_zero();
    logic [63:0] w;
    draw_word(w);
    @(posedge clk_i);
    irq_mode_i  <= SOFTWARE_DEFINED;
    irq_lines_i <= w;
    wait_cycles(3);
    compare_value("unknown_prep", 64'(expected_lines(w)), 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_mode_i <= 32'd7;
    wait_cycles(2);
    compare_value("unknown_mode", '0, 64'(irq_rnd_lines_o));
    wait_cycles(3);
    compare_value("unknown_stay", '0, 64'(irq_rnd_lines_o));
    @(posedge clk_i);
    irq_mode_i  <= STANDARD;
    irq_lines_i <= '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni           = 1'b0;
    irq_i            = 1'b0;
    irq_ack_i        = 1'b0;
    irq_mode_i       = STANDARD;
    irq_min_cycles_i = 32'd3;
    irq_max_cycles_i = 32'd10;
    irq_min_id_i     = 32'd16;
    irq_max_id_i     = 32'd40;
    irq_pc_id_i      = 32'h200;
    irq_pc_trig_i    = 32'h100;
    irq_lines_i      = '0;
    lfsr_q           = 16'd90;
    errors           = 0;
    checks           = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    reset_and_standard();
    software_defined_lines();
    random_lines_window();
    pc_trigger_sequence();
    acknowledge_pulse(1);
    acknowledge_pulse(2);
    acknowledge_pulse(3);
    unknown_mode_zero();
    wait_cycles(2);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/irq_gen_pkg.sv
`default_nettype none

package irq_gen_pkg;

  ////////////////////////////////////////////////////////////
  // Mode codes and widths
  ////////////////////////////////////////////////////////////

  localparam logic [31:0] STANDARD         = 32'd0;
  localparam logic [31:0] RANDOM           = 32'd1;
  localparam logic [31:0] PC_TRIG          = 32'd2;
  localparam logic [31:0] SOFTWARE_DEFINED = 32'd3;

  localparam int IRQ_LINES_NUM = 51;
  localparam int IRQ_WORD_W    = 64;
  localparam int IRQ_ID_W      = 6;

  // Random source FSM encoding
  localparam logic [1:0] RS_IDLE   = 2'd0;
  localparam logic [1:0] RS_WAIT   = 2'd1;
  localparam logic [1:0] RS_RAISED = 2'd2;

  // PC trigger FSM encoding
  localparam logic [1:0] PS_ARMED = 2'd0;
  localparam logic [1:0] PS_WATCH = 2'd1;
  localparam logic [1:0] PS_DONE  = 2'd2;

  ////////////////////////////////////////////////////////////
  // Interrupt word, raw or split into line fields
  ////////////////////////////////////////////////////////////

  typedef union packed {
    logic [IRQ_WORD_W-1:0] raw;
    struct packed {
      logic [47:0] fast;
      logic [3:0]  rsvd_15_12;
      logic        external;
      logic [2:0]  rsvd_10_8;
      logic        timer;
      logic [2:0]  rsvd_6_4;
      logic        software;
      logic [2:0]  rsvd_2_0;
    } lines;
  } irq_word_u;

  // Software on top, fast lines at the bottom, as on the core side
  function automatic logic [IRQ_LINES_NUM-1:0] irq_lines_map(input irq_word_u word);
    return {word.lines.software, word.lines.timer, word.lines.external, word.lines.fast};
  endfunction

endpackage

`default_nettype wire

//--- verilog/irq_mode_select.sv
`timescale 1ns/1ps
`default_nettype none

module irq_mode_select import irq_gen_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [31:0]              irq_mode_i,
  input  wire logic                     irq_ack_i,
  input  wire logic [IRQ_LINES_NUM-1:0] rand_lines_i,
  input  wire logic [IRQ_LINES_NUM-1:0] pc_lines_i,
  input  wire logic [IRQ_LINES_NUM-1:0] sw_lines_i,
  output logic      [31:0]              mode_o,
  output logic      [IRQ_LINES_NUM-1:0] irq_lines_o,
  output logic                          irq_id_we_o
);

  logic [31:0]              mode_q;
  logic [IRQ_LINES_NUM-1:0] lines_d;
  logic [IRQ_LINES_NUM-1:0] lines_q;
  logic                     ack_q;
  logic                     we_q;

  ////////////////////////////////////////////////////////////
  // Line multiplexer
  ////////////////////////////////////////////////////////////

  // STANDARD and unknown codes both give zero
  always_comb begin
    case (mode_q)
      RANDOM:           lines_d = rand_lines_i;
      PC_TRIG:          lines_d = pc_lines_i;
      SOFTWARE_DEFINED: lines_d = sw_lines_i;
      default:          lines_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q  <= STANDARD;
      lines_q <= '0;
      ack_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      mode_q  <= irq_mode_i;
      lines_q <= lines_d;
      ack_q   <= irq_ack_i;
      // One pulse per rising acknowledge
      we_q    <= irq_ack_i & ~ack_q;
    end
  end

  assign mode_o      = mode_q;
  assign irq_lines_o = lines_q;
  assign irq_id_we_o = we_q;

endmodule

`default_nettype wire

//--- verilog/irq_pc_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module irq_pc_trigger import irq_gen_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [31:0]              mode_i,
  input  wire logic [31:0]              pc_id_i,
  input  wire logic [31:0]              pc_trig_i,
  input  wire logic [IRQ_WORD_W-1:0]    lines_i,
  output logic      [IRQ_LINES_NUM-1:0] lines_o
);

  logic [1:0]            state_q;
  logic [IRQ_WORD_W-1:0] snap_q;
  logic [IRQ_LINES_NUM-1:0] lines_q;
  irq_word_u             sw_word;

  // Word with only the software line set
  always_comb begin
    sw_word                = '0;
    sw_word.lines.software = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PS_ARMED;
      lines_q <= '0;
    end else if (mode_i != PC_TRIG) begin
      state_q <= PS_ARMED;
      lines_q <= '0;
    end else begin
      case (state_q)
        PS_ARMED: begin
          if (pc_id_i == pc_trig_i) begin
            lines_q <= irq_lines_map(sw_word);
            state_q <= PS_WATCH;
          end
        end
        PS_WATCH: begin
          // First change of the software word replaces the lines
          if (lines_i != snap_q) begin
            lines_q <= irq_lines_map(irq_word_u'(lines_i));
            state_q <= PS_DONE;
          end
        end
        default: begin
          state_q <= PS_DONE;
        end
      endcase
    end
  end

  // Snapshot taken on the PC match
  always_ff @(posedge clk_i) begin
    if (state_q == PS_ARMED && pc_id_i == pc_trig_i) begin
      snap_q <= lines_i;
    end
  end

  assign lines_o = lines_q;

endmodule

`default_nettype wire

//--- verilog/irq_rand_source.sv
`timescale 1ns/1ps
`default_nettype none

module irq_rand_source import irq_gen_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [31:0]              mode_i,
  input  wire logic [31:0]              min_cycles_i,
  input  wire logic [31:0]              max_cycles_i,
  input  wire logic [31:0]              min_id_i,
  input  wire logic [31:0]              max_id_i,
  output logic      [IRQ_LINES_NUM-1:0] lines_o,
  output logic      [31:0]              act_id_o
);

  logic [IRQ_WORD_W-1:0] lfsr_q;
  logic                  lfsr_fb;
  logic [IRQ_WORD_W-1:0] bound_mask;
  logic [32:0]           wait_sum;
  logic [31:0]           wait_cnt;
  logic [1:0]            state_q;
  logic [31:0]           cnt_q;
  irq_word_u             word_q;
  logic [IRQ_ID_W-1:0]   act_id;

  // Taps 64, 63, 61, 60 give a maximal length sequence
  assign lfsr_fb = lfsr_q[63] ^ lfsr_q[62] ^ lfsr_q[60] ^ lfsr_q[59];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 64'hACE1_2468_0F0F_1357;
    end else begin
      lfsr_q <= {lfsr_q[IRQ_WORD_W-2:0], lfsr_fb};
    end
  end

  // Keep only IDs inside [min_id, max_id]
  always_comb begin
    for (int i = 0; i < IRQ_WORD_W; i++) begin
      bound_mask[i] = (32'(i) >= min_id_i) && (32'(i) <= max_id_i);
    end
  end

  // Wait is min plus a random offset, capped at max
  assign wait_sum = {1'b0, min_cycles_i} + {17'b0, lfsr_q[15:0]};
  assign wait_cnt = (wait_sum > {1'b0, max_cycles_i}) ? max_cycles_i : wait_sum[31:0];

  ////////////////////////////////////////////////////////////
  // Arm, wait, raise
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RS_IDLE;
      cnt_q      <= '0;
      word_q.raw <= '0;
    end else if (mode_i != RANDOM) begin
      // Leaving the mode drops everything, next entry re-arms
      state_q    <= RS_IDLE;
      word_q.raw <= '0;
    end else begin
      case (state_q)
        RS_IDLE: begin
          word_q.raw <= lfsr_q & bound_mask;
          cnt_q      <= wait_cnt;
          state_q    <= RS_WAIT;
        end
        RS_WAIT: begin
          if (cnt_q == '0) begin
            state_q <= RS_RAISED;
          end else begin
            cnt_q <= cnt_q - 32'd1;
          end
        end
        default: begin
          // Held until the mode leaves RANDOM
          state_q <= RS_RAISED;
        end
      endcase
    end
  end

  assign lines_o = (state_q == RS_RAISED) ? irq_lines_map(word_q) : '0;

  // Highest set ID wins
  always_comb begin
    act_id = '0;
    for (int i = 0; i < IRQ_WORD_W; i++) begin
      if (word_q.raw[i]) begin
        act_id = IRQ_ID_W'(i);
      end
    end
  end

  assign act_id_o = {{(32-IRQ_ID_W){1'b0}}, act_id};

endmodule

`default_nettype wire

//--- verilog/irq_stim_gen.sv
`timescale 1ns/1ps
`default_nettype none

module irq_stim_gen import irq_gen_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Harness compatibility only, no function
  input  wire logic                     irq_i,
  input  wire logic                     irq_ack_i,
  input  wire logic [31:0]              irq_mode_i,
  input  wire logic [31:0]              irq_min_cycles_i,
  input  wire logic [31:0]              irq_max_cycles_i,
  input  wire logic [31:0]              irq_min_id_i,
  input  wire logic [31:0]              irq_max_id_i,
  input  wire logic [31:0]              irq_pc_id_i,
  input  wire logic [31:0]              irq_pc_trig_i,
  input  wire logic [IRQ_WORD_W-1:0]    irq_lines_i,
  output logic      [IRQ_LINES_NUM-1:0] irq_rnd_lines_o,
  output logic                          irq_ack_o,
  output logic      [31:0]              irq_act_id_o,
  output logic                          irq_id_we_o
);

  logic [31:0]              mode_q;
  logic [IRQ_LINES_NUM-1:0] rand_lines;
  logic [IRQ_LINES_NUM-1:0] pc_lines;
  logic [IRQ_LINES_NUM-1:0] sw_lines;
  logic [31:0]              rand_id;

  ////////////////////////////////////////////////////////////
  // Sources
  ////////////////////////////////////////////////////////////

  irq_rand_source irq_rand_source_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mode_i       (mode_q),
    .min_cycles_i (irq_min_cycles_i),
    .max_cycles_i (irq_max_cycles_i),
    .min_id_i     (irq_min_id_i),
    .max_id_i     (irq_max_id_i),
    .lines_o      (rand_lines),
    .act_id_o     (rand_id)
  );

  irq_pc_trigger irq_pc_trigger_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mode_i    (mode_q),
    .pc_id_i   (irq_pc_id_i),
    .pc_trig_i (irq_pc_trig_i),
    .lines_i   (irq_lines_i),
    .lines_o   (pc_lines)
  );

  irq_sw_sampler irq_sw_sampler_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .mode_i  (mode_q),
    .lines_i (irq_lines_i),
    .lines_o (sw_lines)
  );

  ////////////////////////////////////////////////////////////
  // Mode register and output stage
  ////////////////////////////////////////////////////////////

  irq_mode_select irq_mode_select_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_mode_i   (irq_mode_i),
    .irq_ack_i    (irq_ack_i),
    .rand_lines_i (rand_lines),
    .pc_lines_i   (pc_lines),
    .sw_lines_i   (sw_lines),
    .mode_o       (mode_q),
    .irq_lines_o  (irq_rnd_lines_o),
    .irq_id_we_o  (irq_id_we_o)
  );

  // Acknowledge goes straight through
  assign irq_ack_o    = irq_ack_i;
  assign irq_act_id_o = rand_id;

endmodule

`default_nettype wire

//--- verilog/irq_sw_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module irq_sw_sampler import irq_gen_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [31:0]              mode_i,
  input  wire logic [IRQ_WORD_W-1:0]    lines_i,
  output logic      [IRQ_LINES_NUM-1:0] lines_o
);

  logic [IRQ_LINES_NUM-1:0] lines_q;
  logic                     sample;

  // A zero word means no update, last lines stay
  assign sample = (mode_i == SOFTWARE_DEFINED) && (lines_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lines_q <= '0;
    end else if (mode_i != SOFTWARE_DEFINED) begin
      lines_q <= '0;
    end else if (sample) begin
      // Reserved bits of the word are dropped by the mapping
      lines_q <= irq_lines_map(irq_word_u'(lines_i));
    end
  end

  assign lines_o = lines_q;

endmodule

`default_nettype wire
